/* verilog/csr_config.svh */
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

`define CSR_XLEN             32
`define CSR_HART_ID          32'h0000_0000
`define CSR_MISA_VALUE       32'h4010_0100  // MXL=1, I and U extensions
`define CSR_MSTATUS_RESET    32'h0020_0000  // tw set, mpp at U
`define CSR_MCOUNTEREN_RESET 32'h0000_0005  // cy and ir

// Machine information, read-only space
`define CSR_MVENDORID_ADDR     12'hF11
`define CSR_MARCHID_ADDR       12'hF12
`define CSR_MIMPID_ADDR        12'hF13
`define CSR_MHARTID_ADDR       12'hF14
`define CSR_MCONFIGPTR_ADDR    12'hF15

// Machine trap setup and handling
`define CSR_MSTATUS_ADDR       12'h300
`define CSR_MISA_ADDR          12'h301
`define CSR_MIE_ADDR           12'h304
`define CSR_MTVEC_ADDR         12'h305
`define CSR_MCOUNTEREN_ADDR    12'h306
`define CSR_MSTATUSH_ADDR      12'h310
`define CSR_MCOUNTINHIBIT_ADDR 12'h320
`define CSR_MSCRATCH_ADDR      12'h340
`define CSR_MEPC_ADDR          12'h341
`define CSR_MCAUSE_ADDR        12'h342
`define CSR_MTVAL_ADDR         12'h343
`define CSR_MIP_ADDR           12'h344

// Machine counters
`define CSR_MCYCLE_ADDR        12'hB00
`define CSR_MINSTRET_ADDR      12'hB02
`define CSR_MCYCLEH_ADDR       12'hB80
`define CSR_MINSTRETH_ADDR     12'hB82

// User shadows of the counters
`define CSR_CYCLE_ADDR         12'hC00
`define CSR_INSTRET_ADDR       12'hC02
`define CSR_CYCLEH_ADDR        12'hC80
`define CSR_INSTRETH_ADDR      12'hC82

`endif

/* verilog/csr_pkg.sv */
`default_nettype none

`include "csr_config.svh"

package csr_pkg;

  typedef enum logic [1:0] {
    PRIV_U    = 2'b00,
    PRIV_S    = 2'b01,
    PRIV_RSVD = 2'b10,
    PRIV_M    = 2'b11
  } priv_level_t;

  typedef enum logic [2:0] {
    OP_NONE  = 3'd0,
    OP_READ  = 3'd1,
    OP_WRITE = 3'd2,
    OP_SET   = 3'd3,
    OP_CLEAR = 3'd4
  } csr_op_t;

  // One entry per implemented address
  typedef enum logic [4:0] {
    SEL_UNKNOWN,
    SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID, SEL_MCONFIGPTR,
    SEL_MSTATUS, SEL_MISA, SEL_MIE, SEL_MTVEC, SEL_MCOUNTEREN,
    SEL_MSTATUSH, SEL_MCOUNTINHIBIT,
    SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MIP,
    SEL_MCYCLE, SEL_MINSTRET, SEL_MCYCLEH, SEL_MINSTRETH,
    SEL_CYCLE, SEL_INSTRET, SEL_CYCLEH, SEL_INSTRETH
  } csr_sel_t;

  typedef struct packed {
    logic [11:0]          addr;
    csr_op_t              op;
    logic [`CSR_XLEN-1:0] operand;
  } csr_req_t;

  // Supervisor and extension-state fields are folded into reserved
  typedef struct packed {
    logic [9:0]  reserved_4;  // 31:22
    logic        tw;
    logic [2:0]  reserved_3;  // tvm, mxr, sum
    logic        mprv;
    logic [3:0]  reserved_2;  // xs, fs
    priv_level_t mpp;
    logic [2:0]  reserved_1;  // vs, spp
    logic        mpie;
    logic [2:0]  reserved_0;  // ube, spie
    logic        mie;
    logic [2:0]  reserved;
  } mstatus_t;

  typedef struct packed {
    logic [29:0] base;
    logic [1:0]  mode;  // 0 direct, 1 vectored
  } mtvec_t;

  typedef struct packed {
    logic [19:0] reserved_3;
    logic        meie;
    logic [2:0]  reserved_2;
    logic        mtie;
    logic [2:0]  reserved_1;
    logic        msie;
    logic [2:0]  reserved_0;
  } mie_t;

  typedef struct packed {
    logic [19:0] reserved_3;
    logic        meip;
    logic [2:0]  reserved_2;
    logic        mtip;
    logic [2:0]  reserved_1;
    logic        msip;
    logic [2:0]  reserved_0;
  } mip_t;

  // Shared by mcounteren and mcountinhibit
  typedef struct packed {
    logic [28:0] reserved_1;  // hpm counters not implemented
    logic        ir;
    logic        reserved_0;  // no time CSR
    logic        cy;
  } mcounteren_t;

  typedef struct packed {
    logic                 mstatus_en;
    logic                 mepc_en;
    logic                 mcause_en;
    logic                 mtval_en;
    logic                 mip_en;
    mstatus_t             mstatus;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;
    mip_t                 mip;
  } trap_inject_t;

  typedef struct packed {
    mstatus_t             mstatus;
    mtvec_t               mtvec;
    mie_t                 mie;
    mip_t                 mip;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
  } trap_state_t;

endpackage

`default_nettype wire

/* verilog/csr_access_check.sv */
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_access_check (
  input  csr_pkg::csr_req_t    req,
  input  csr_pkg::priv_level_t curr_priv,
  input  logic [`CSR_XLEN-1:0] rdata,
  output csr_pkg::csr_sel_t    sel,
  output logic                 priv_fault,
  output logic                 write_en,
  output logic [`CSR_XLEN-1:0] wdata
);
  import csr_pkg::*;

  logic is_write;
  logic read_only;
  logic low_priv;

  assign is_write  = (req.op == OP_WRITE) || (req.op == OP_SET) || (req.op == OP_CLEAR);
  assign read_only = &req.addr[11:10];  // 0xC00 and up
  assign low_priv  = req.addr[9:8] > curr_priv;

  // Read-only rule first, then privilege for any active op
  always_comb begin
    if (read_only && is_write) begin
      priv_fault = 1'b1;
    end else begin
      priv_fault = low_priv && (req.op != OP_NONE);
    end
  end

  assign write_en = is_write && !priv_fault;

  always_comb begin
    case (req.addr)
      `CSR_MVENDORID_ADDR:     sel = SEL_MVENDORID;
      `CSR_MARCHID_ADDR:       sel = SEL_MARCHID;
      `CSR_MIMPID_ADDR:        sel = SEL_MIMPID;
      `CSR_MHARTID_ADDR:       sel = SEL_MHARTID;
      `CSR_MCONFIGPTR_ADDR:    sel = SEL_MCONFIGPTR;
      `CSR_MSTATUS_ADDR:       sel = SEL_MSTATUS;
      `CSR_MISA_ADDR:          sel = SEL_MISA;
      `CSR_MIE_ADDR:           sel = SEL_MIE;
      `CSR_MTVEC_ADDR:         sel = SEL_MTVEC;
      `CSR_MCOUNTEREN_ADDR:    sel = SEL_MCOUNTEREN;
      `CSR_MSTATUSH_ADDR:      sel = SEL_MSTATUSH;
      `CSR_MCOUNTINHIBIT_ADDR: sel = SEL_MCOUNTINHIBIT;
      `CSR_MSCRATCH_ADDR:      sel = SEL_MSCRATCH;
      `CSR_MEPC_ADDR:          sel = SEL_MEPC;
      `CSR_MCAUSE_ADDR:        sel = SEL_MCAUSE;
      `CSR_MTVAL_ADDR:         sel = SEL_MTVAL;
      `CSR_MIP_ADDR:           sel = SEL_MIP;
      `CSR_MCYCLE_ADDR:        sel = SEL_MCYCLE;
      `CSR_MINSTRET_ADDR:      sel = SEL_MINSTRET;
      `CSR_MCYCLEH_ADDR:       sel = SEL_MCYCLEH;
      `CSR_MINSTRETH_ADDR:     sel = SEL_MINSTRETH;
      `CSR_CYCLE_ADDR:         sel = SEL_CYCLE;
      `CSR_INSTRET_ADDR:       sel = SEL_INSTRET;
      `CSR_CYCLEH_ADDR:        sel = SEL_CYCLEH;
      `CSR_INSTRETH_ADDR:      sel = SEL_INSTRETH;
      default:                 sel = SEL_UNKNOWN;
    endcase
  end

  // Set and clear modify the current read value
  always_comb begin
    case (req.op)
      OP_SET:   wdata = rdata | req.operand;
      OP_CLEAR: wdata = rdata & ~req.operand;
      default:  wdata = req.operand;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/csr_machine_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_machine_regs (
  input  logic                  CLK,
  input  logic                  nRST,
  input  csr_pkg::csr_sel_t     sel,
  input  logic                  write_en,
  input  logic [`CSR_XLEN-1:0]  wdata,
  input  csr_pkg::trap_inject_t inject,
  output csr_pkg::trap_state_t  trap_state,
  output logic [`CSR_XLEN-1:0]  mscratch,
  output logic [`CSR_XLEN-1:0]  mtval,
  output csr_pkg::mcounteren_t  mcounteren,
  output csr_pkg::mcounteren_t  mcountinhibit
);
  import csr_pkg::*;

  localparam logic [`CSR_XLEN-1:0] IRQ_MASK = 32'h0000_0888;  // meie/mtie/msie
  localparam logic [`CSR_XLEN-1:0] CNT_MASK = 32'h0000_0005;  // ir and cy

  mstatus_t             mstatus;
  mstatus_t             mstatus_next;
  mtvec_t               mtvec;
  mtvec_t               mtvec_next;
  mie_t                 mie;
  mie_t                 mie_next;
  mip_t                 mip;
  mip_t                 mip_next;
  logic [`CSR_XLEN-1:0] mepc;
  logic [`CSR_XLEN-1:0] mepc_next;
  logic [`CSR_XLEN-1:0] mcause;
  logic [`CSR_XLEN-1:0] mcause_next;
  logic [`CSR_XLEN-1:0] mscratch_next;
  logic [`CSR_XLEN-1:0] mtval_next;
  mcounteren_t          mcounteren_next;
  mcounteren_t          mcountinhibit_next;

  // Only M and U exist, anything else lands in U
  function automatic mstatus_t legal_mstatus(logic [`CSR_XLEN-1:0] v);
    mstatus_t r;
    r      = '0;
    r.mie  = v[3];
    r.mpie = v[7];
    r.mpp  = (v[12:11] == 2'b11) ? PRIV_M : PRIV_U;
    r.mprv = v[17];
    r.tw   = v[21];
    return r;
  endfunction

  function automatic mtvec_t legal_mtvec(logic [`CSR_XLEN-1:0] v);
    mtvec_t r;
    r.base = v[31:2];
    r.mode = (v[1:0] > 2'b01) ? 2'b00 : v[1:0];  // Reserved modes become direct
    return r;
  endfunction

  always_comb begin
    mstatus_next       = mstatus;
    mtvec_next         = mtvec;
    mie_next           = mie;
    mip_next           = mip;
    mscratch_next      = mscratch;
    mepc_next          = mepc;
    mcause_next        = mcause;
    mtval_next         = mtval;
    mcounteren_next    = mcounteren;
    mcountinhibit_next = mcountinhibit;

    if (write_en) begin
      case (sel)
        SEL_MSTATUS:       mstatus_next = legal_mstatus(wdata);
        SEL_MTVEC:         mtvec_next = legal_mtvec(wdata);
        SEL_MIE:           mie_next = mie_t'(wdata & IRQ_MASK);
        SEL_MIP:           mip_next = mip_t'(wdata & IRQ_MASK);
        SEL_MSCRATCH:      mscratch_next = wdata;
        SEL_MEPC:          mepc_next = wdata;
        SEL_MCAUSE:        mcause_next = wdata;
        SEL_MTVAL:         mtval_next = wdata;
        SEL_MCOUNTEREN:    mcounteren_next = mcounteren_t'(wdata & CNT_MASK);
        SEL_MCOUNTINHIBIT: mcountinhibit_next = mcounteren_t'(wdata & CNT_MASK);
        default: ;  // Counters and constants live elsewhere
      endcase
    end

    // Trap handler has the last word
    if (inject.mstatus_en) begin
      mstatus_next = legal_mstatus(inject.mstatus);
    end
    if (inject.mepc_en) begin
      mepc_next = inject.mepc;
    end
    if (inject.mcause_en) begin
      mcause_next = inject.mcause;
    end
    if (inject.mtval_en) begin
      mtval_next = inject.mtval;
    end
    if (inject.mip_en) begin
      mip_next = mip_t'(inject.mip & IRQ_MASK);
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus       <= mstatus_t'(`CSR_MSTATUS_RESET);
      mtvec         <= '0;
      mie           <= '0;
      mip           <= '0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= mcounteren_t'(`CSR_MCOUNTEREN_RESET);
      mcountinhibit <= '0;
    end else begin
      mstatus       <= mstatus_next;
      mtvec         <= mtvec_next;
      mie           <= mie_next;
      mip           <= mip_next;
      mscratch      <= mscratch_next;
      mepc          <= mepc_next;
      mcause        <= mcause_next;
      mtval         <= mtval_next;
      mcounteren    <= mcounteren_next;
      mcountinhibit <= mcountinhibit_next;
    end
  end

  // Straight from the flops back to the trap handler
  assign trap_state.mstatus = mstatus;
  assign trap_state.mtvec   = mtvec;
  assign trap_state.mie     = mie;
  assign trap_state.mip     = mip;
  assign trap_state.mepc    = mepc;
  assign trap_state.mcause  = mcause;

endmodule

`default_nettype wire

/* verilog/csr_counter64.sv */
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_counter64 #(
  parameter csr_pkg::csr_sel_t LO_SEL = csr_pkg::SEL_MCYCLE,
  parameter csr_pkg::csr_sel_t HI_SEL = csr_pkg::SEL_MCYCLEH
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  csr_pkg::csr_sel_t      sel,
  input  logic                   write_en,
  input  logic [`CSR_XLEN-1:0]   wdata,
  input  logic                   inc,
  input  logic                   inhibit,
  output logic [2*`CSR_XLEN-1:0] count
);

  logic load_lo;
  logic load_hi;

  assign load_lo = write_en && (sel == LO_SEL);
  assign load_hi = write_en && (sel == HI_SEL);

  // A half write replaces that edge's increment
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else if (load_lo) begin
      count[`CSR_XLEN-1:0] <= wdata;
    end else if (load_hi) begin
      count[2*`CSR_XLEN-1:`CSR_XLEN] <= wdata;
    end else if (!inhibit) begin
      count <= count + {{(2*`CSR_XLEN-1){1'b0}}, inc};
    end
  end

endmodule

`default_nettype wire

/* verilog/csr_read_mux.sv */
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_read_mux (
  input  csr_pkg::csr_sel_t      sel,
  input  csr_pkg::priv_level_t   curr_priv,
  input  csr_pkg::csr_op_t       op,
  input  csr_pkg::trap_state_t   trap_state,
  input  logic [`CSR_XLEN-1:0]   mscratch,
  input  logic [`CSR_XLEN-1:0]   mtval,
  input  csr_pkg::mcounteren_t   mcounteren,
  input  csr_pkg::mcounteren_t   mcountinhibit,
  input  logic [2*`CSR_XLEN-1:0] cycle_count,
  input  logic [2*`CSR_XLEN-1:0] instret_count,
  input  logic                   priv_fault,
  output logic [`CSR_XLEN-1:0]   rdata,
  output logic                   invalid_csr
);
  import csr_pkg::*;

  logic [`CSR_XLEN-1:0] value;
  logic                 op_active;
  logic                 cnt_gate;
  logic                 cnt_blocked;
  logic                 cnt_fault;
  logic                 unknown_fault;
  logic                 addr_fault;

  always_comb begin
    case (sel)
      SEL_MHARTID:       value = `CSR_HART_ID;
      SEL_MISA:          value = `CSR_MISA_VALUE;
      SEL_MSTATUS:       value = trap_state.mstatus;
      SEL_MTVEC:         value = trap_state.mtvec;
      SEL_MIE:           value = trap_state.mie;
      SEL_MIP:           value = trap_state.mip;
      SEL_MEPC:          value = trap_state.mepc;
      SEL_MCAUSE:        value = trap_state.mcause;
      SEL_MSCRATCH:      value = mscratch;
      SEL_MTVAL:         value = mtval;
      SEL_MCOUNTEREN:    value = mcounteren;
      SEL_MCOUNTINHIBIT: value = mcountinhibit;
      SEL_MCYCLE,
      SEL_CYCLE:         value = cycle_count[`CSR_XLEN-1:0];
      SEL_MCYCLEH,
      SEL_CYCLEH:        value = cycle_count[2*`CSR_XLEN-1:`CSR_XLEN];
      SEL_MINSTRET,
      SEL_INSTRET:       value = instret_count[`CSR_XLEN-1:0];
      SEL_MINSTRETH,
      SEL_INSTRETH:      value = instret_count[2*`CSR_XLEN-1:`CSR_XLEN];
      // Vendor, arch, impl, config pointer and mstatush all read zero
      default:           value = '0;
    endcase
  end

  // Shadow counters need their mcounteren bit in U mode
  always_comb begin
    case (sel)
      SEL_CYCLE,
      SEL_CYCLEH:   cnt_gate = !mcounteren.cy;
      SEL_INSTRET,
      SEL_INSTRETH: cnt_gate = !mcounteren.ir;
      default:      cnt_gate = 1'b0;
    endcase
  end

  assign op_active     = op != OP_NONE;
  assign cnt_blocked   = cnt_gate && (curr_priv == PRIV_U);
  assign cnt_fault     = cnt_blocked && op_active;
  assign unknown_fault = (sel == SEL_UNKNOWN) && op_active;
  assign addr_fault    = unknown_fault || cnt_fault;

  assign rdata       = cnt_blocked ? '0 : value;  // Hide blocked counters
  assign invalid_csr = priv_fault || addr_fault;

endmodule

`default_nettype wire

/* verilog/csr_file_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_file_top (
  input  logic                  CLK,
  input  logic                  nRST,
  input  csr_pkg::csr_req_t     req,
  input  csr_pkg::priv_level_t  curr_priv,
  input  logic                  inst_ret,
  input  csr_pkg::trap_inject_t inject,
  output logic [`CSR_XLEN-1:0]  rdata,
  output logic                  invalid_csr,
  output csr_pkg::trap_state_t  trap_state
);
  import csr_pkg::*;

  csr_sel_t               sel;
  logic                   priv_fault;
  logic                   write_en;
  logic [`CSR_XLEN-1:0]   wdata;
  logic [`CSR_XLEN-1:0]   mscratch;
  logic [`CSR_XLEN-1:0]   mtval;
  mcounteren_t            mcounteren;
  mcounteren_t            mcountinhibit;
  logic [2*`CSR_XLEN-1:0] cycle_count;
  logic [2*`CSR_XLEN-1:0] instret_count;

  // Decode and access rules, feeds the single write enable
  csr_access_check u_access_check (
    .req        (req),
    .curr_priv  (curr_priv),
    .rdata      (rdata),
    .sel        (sel),
    .priv_fault (priv_fault),
    .write_en   (write_en),
    .wdata      (wdata)
  );

  csr_machine_regs u_machine_regs (
    .CLK           (CLK),
    .nRST          (nRST),
    .sel           (sel),
    .write_en      (write_en),
    .wdata         (wdata),
    .inject        (inject),
    .trap_state    (trap_state),
    .mscratch      (mscratch),
    .mtval         (mtval),
    .mcounteren    (mcounteren),
    .mcountinhibit (mcountinhibit)
  );

  csr_counter64 #(
    .LO_SEL (SEL_MCYCLE),
    .HI_SEL (SEL_MCYCLEH)
  ) u_cycle (
    .CLK      (CLK),
    .nRST     (nRST),
    .sel      (sel),
    .write_en (write_en),
    .wdata    (wdata),
    .inc      (1'b1),  // Every clock
    .inhibit  (mcountinhibit.cy),
    .count    (cycle_count)
  );

  csr_counter64 #(
    .LO_SEL (SEL_MINSTRET),
    .HI_SEL (SEL_MINSTRETH)
  ) u_instret (
    .CLK      (CLK),
    .nRST     (nRST),
    .sel      (sel),
    .write_en (write_en),
    .wdata    (wdata),
    .inc      (inst_ret),
    .inhibit  (mcountinhibit.ir),
    .count    (instret_count)
  );

  csr_read_mux u_read_mux (
    .sel           (sel),
    .curr_priv     (curr_priv),
    .op            (req.op),
    .trap_state    (trap_state),
    .mscratch      (mscratch),
    .mtval         (mtval),
    .mcounteren    (mcounteren),
    .mcountinhibit (mcountinhibit),
    .cycle_count   (cycle_count),
    .instret_count (instret_count),
    .priv_fault    (priv_fault),
    .rdata         (rdata),
    .invalid_csr   (invalid_csr)
  );

endmodule

`default_nettype wire

/* bench/csr_file_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_file_assertions (
  input logic                  CLK,
  input logic                  nRST,
  input csr_pkg::csr_req_t     req,
  input csr_pkg::priv_level_t  curr_priv,
  input csr_pkg::trap_inject_t inject,
  input csr_pkg::trap_state_t  trap_state,
  input csr_pkg::mcounteren_t  mcounteren,
  input logic [`CSR_XLEN-1:0]  rdata,
  input logic                  invalid_csr
);
  import csr_pkg::*;

  int   fail_count = 0;  // Failed assertions so far
  logic shadow_cy;
  logic shadow_ir;
  logic cnt_blocked;

  assign shadow_cy   = (req.addr == `CSR_CYCLE_ADDR) || (req.addr == `CSR_CYCLEH_ADDR);
  assign shadow_ir   = (req.addr == `CSR_INSTRET_ADDR) || (req.addr == `CSR_INSTRETH_ADDR);
  // Counter-enable fault as seen from the ports
  assign cnt_blocked = (curr_priv == PRIV_U) && (req.op != OP_NONE) &&
                       ((shadow_cy && !mcounteren.cy) || (shadow_ir && !mcounteren.ir));

  idle_no_fault: assert property (@(posedge CLK) disable iff (!nRST)
    (req.op == OP_NONE) |-> !invalid_csr)
  else begin
    fail_count++;
    $error("invalid_csr high while op is NONE");
  end

  mepc_inject: assert property (@(posedge CLK) disable iff (!nRST)
    inject.mepc_en |=> (trap_state.mepc == $past(inject.mepc)))
  else begin
    fail_count++;
    $error("injected mepc missing on trap_state");
  end

  blocked_reads_zero: assert property (@(posedge CLK) disable iff (!nRST)
    cnt_blocked |-> (invalid_csr && (rdata == '0)))
  else begin
    fail_count++;
    $error("blocked counter read returned data");
  end

endmodule

bind csr_file_top csr_file_assertions u_assertions (
  .CLK         (CLK),
  .nRST        (nRST),
  .req         (req),
  .curr_priv   (curr_priv),
  .inject      (inject),
  .trap_state  (trap_state),
  .mcounteren  (mcounteren),
  .rdata       (rdata),
  .invalid_csr (invalid_csr)
);

`default_nettype wire

/* bench/csr_file_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_file_tb;
  import csr_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int RANDOM_OPS   = 400;
  localparam int INJECTIONS   = 60;
  localparam int MAX_CYCLES   = 5000;  // Several times the full run

  logic                 CLK;
  logic                 nRST;
  csr_req_t             req;
  priv_level_t          curr_priv;
  logic                 inst_ret;
  trap_inject_t         inject;
  logic [`CSR_XLEN-1:0] rdata;
  logic                 invalid_csr;
  trap_state_t          trap_state;

  integer       seed;
  int           cycles;
  int           errors;
  int           test_errors;
  int           tests_run;
  int           tests_failed;
  int           checks;
  int           idx;
  int           pick;
  int           n;
  int           pulses;
  int           start;
  csr_op_t      op;
  logic [31:0]  operand;
  logic [31:0]  next_val;
  logic [31:0]  first;
  logic [31:0]  inst_value;
  logic [31:0]  rnd;
  logic [1:0]   en_bits;
  trap_inject_t inj;

  // mstatus, mtvec, mie, mip, mscratch, mepc, mcause, mtval, mcounteren, mcountinhibit
  logic [31:0] model_reg [10];

  csr_file_top u_csr_file_top (
    .CLK         (CLK),
    .nRST        (nRST),
    .req         (req),
    .curr_priv   (curr_priv),
    .inst_ret    (inst_ret),
    .inject      (inject),
    .rdata       (rdata),
    .invalid_csr (invalid_csr),
    .trap_state  (trap_state)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic logic [11:0] reg_addr(int i);
    case (i)
      0:       return `CSR_MSTATUS_ADDR;
      1:       return `CSR_MTVEC_ADDR;
      2:       return `CSR_MIE_ADDR;
      3:       return `CSR_MIP_ADDR;
      4:       return `CSR_MSCRATCH_ADDR;
      5:       return `CSR_MEPC_ADDR;
      6:       return `CSR_MCAUSE_ADDR;
      7:       return `CSR_MTVAL_ADDR;
      8:       return `CSR_MCOUNTEREN_ADDR;
      default: return `CSR_MCOUNTINHIBIT_ADDR;
    endcase
  endfunction

  // Value a register holds after a write of v
  function automatic logic [31:0] legalize(int i, logic [31:0] v);
    logic [31:0] r;
    case (i)
      0: begin
        r = v & 32'h0022_0088;  // tw, mprv, mpie, mie
        if (v[12:11] == 2'b11)
          r[12:11] = 2'b11;  // mpp keeps M only
      end
      1:       r = (v[1:0] > 2'b01) ? {v[31:2], 2'b00} : v;
      2, 3:    r = v & 32'h0000_0888;
      8, 9:    r = v & 32'h0000_0005;
      default: r = v;
    endcase
    return r;
  endfunction

  task automatic expect_value(input string msg, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %0s, got %h, expected %h", $time, msg, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %0s: ok", name);
    end else begin
      $display("Test %0s: %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  task automatic drive_op(input logic [11:0] addr, input csr_op_t o,
                          input logic [31:0] value, input priv_level_t priv);
    @(posedge CLK);
    req       <= {addr, o, value};
    curr_priv <= priv;
    inst_ret  <= 1'b0;
    inject    <= '0;
    @(negedge CLK);
  endtask

  task automatic idle_cycle(input logic pulse);
    @(posedge CLK);
    req      <= '0;
    inst_ret <= pulse;
    inject   <= '0;
    @(negedge CLK);
  endtask

  task automatic check_read(input logic [11:0] addr, input logic [31:0] exp);
    drive_op(addr, OP_READ, 32'h0, PRIV_M);
    expect_value($sformatf("read of %h", addr), rdata, exp);
    expect_value($sformatf("invalid_csr on read of %h", addr), invalid_csr, 0);
  endtask

  task automatic check_fault(input logic [11:0] addr, input csr_op_t o,
                             input priv_level_t priv, input logic exp);
    drive_op(addr, o, $random(seed), priv);
    expect_value($sformatf("invalid_csr for %0s at %h", o.name(), addr), invalid_csr, exp);
  endtask

  initial begin
    seed      = 25544;
    cycles    = 0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    nRST      = 1'b0;
    req       = '0;
    curr_priv = PRIV_M;
    inst_ret  = 1'b0;
    inject    = '0;
    test_errors  = 0;
    tests_failed = 0;
    for (int i = 0; i < 10; i++)
      model_reg[i] = '0;
    model_reg[0] = `CSR_MSTATUS_RESET;
    model_reg[8] = `CSR_MCOUNTEREN_RESET;
    repeat (RESET_CYCLES) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);

    // 1. Reset values
    expect_value("invalid_csr idle after reset", invalid_csr, 0);
    check_read(`CSR_MVENDORID_ADDR, 0);
    check_read(`CSR_MARCHID_ADDR, 0);
    check_read(`CSR_MIMPID_ADDR, 0);
    check_read(`CSR_MHARTID_ADDR, `CSR_HART_ID);
    check_read(`CSR_MCONFIGPTR_ADDR, 0);
    check_read(`CSR_MISA_ADDR, `CSR_MISA_VALUE);
    check_read(`CSR_MSTATUSH_ADDR, 0);
    for (int i = 0; i < 10; i++)
      check_read(reg_addr(i), model_reg[i]);
    check_read(`CSR_MCYCLEH_ADDR, 0);
    check_read(`CSR_MINSTRET_ADDR, 0);
    check_read(`CSR_MINSTRETH_ADDR, 0);
    check_read(`CSR_CYCLEH_ADDR, 0);
    check_read(`CSR_INSTRET_ADDR, 0);
    check_read(`CSR_INSTRETH_ADDR, 0);
    close_test("reset values");

    // 2. Each random operation checks the result of the one before
    for (int i = 0; i < RANDOM_OPS; i++) begin
      idx     = $unsigned($random(seed)) % 10;
      op      = csr_op_t'(1 + $unsigned($random(seed)) % 4);
      operand = $random(seed);
      drive_op(reg_addr(idx), op, operand, PRIV_M);
      expect_value($sformatf("random %0s of %h", op.name(), reg_addr(idx)),
                   rdata, model_reg[idx]);
      expect_value("invalid_csr on random op", invalid_csr, 0);
      case (op)
        OP_SET:   next_val = model_reg[idx] | operand;
        OP_CLEAR: next_val = model_reg[idx] & ~operand;
        default:  next_val = operand;
      endcase
      if (op != OP_READ)
        model_reg[idx] = legalize(idx, next_val);
    end
    for (int i = 0; i < 10; i++)
      check_read(reg_addr(i), model_reg[i]);
    close_test("random operations");

    // 3. Access faults
    check_fault(`CSR_MSCRATCH_ADDR, OP_WRITE, PRIV_U, 1'b1);
    check_fault(`CSR_MSTATUS_ADDR, OP_SET, PRIV_U, 1'b1);
    check_fault(`CSR_MEPC_ADDR, OP_READ, PRIV_U, 1'b1);
    check_read(`CSR_MSCRATCH_ADDR, model_reg[4]);
    check_read(`CSR_MSTATUS_ADDR, model_reg[0]);
    check_fault(`CSR_MHARTID_ADDR, OP_WRITE, PRIV_M, 1'b1);
    check_fault(`CSR_MVENDORID_ADDR, OP_SET, PRIV_M, 1'b1);
    check_fault(`CSR_CYCLE_ADDR, OP_WRITE, PRIV_M, 1'b1);
    check_fault(`CSR_INSTRETH_ADDR, OP_CLEAR, PRIV_M, 1'b1);
    check_fault(`CSR_INSTRET_ADDR, OP_WRITE, PRIV_M, 1'b1);
    check_read(`CSR_MHARTID_ADDR, `CSR_HART_ID);
    check_read(`CSR_MVENDORID_ADDR, 0);
    check_read(`CSR_INSTRET_ADDR, 0);
    check_read(`CSR_INSTRETH_ADDR, 0);
    check_fault(12'h180, OP_READ, PRIV_M, 1'b1);  // satp needs S mode
    check_fault(12'h7C0, OP_WRITE, PRIV_M, 1'b1);
    check_fault(12'h7C0, OP_NONE, PRIV_M, 1'b0);
    close_test("access faults");

    // 4. Counters
    drive_op(`CSR_MCOUNTINHIBIT_ADDR, OP_WRITE, 32'h0, PRIV_M);
    model_reg[9] = '0;
    repeat (5) begin
      drive_op(`CSR_MCYCLE_ADDR, OP_READ, 32'h0, PRIV_M);
      first = rdata;
      start = cycles;
      n     = 1 + $unsigned($random(seed)) % 40;
      repeat (n) idle_cycle(1'b0);
      drive_op(`CSR_MCYCLE_ADDR, OP_READ, 32'h0, PRIV_M);
      expect_value("mcycle step", rdata - first, cycles - start);
    end
    drive_op(`CSR_MCOUNTINHIBIT_ADDR, OP_WRITE, 32'h1, PRIV_M);
    drive_op(`CSR_MCYCLE_ADDR, OP_READ, 32'h0, PRIV_M);
    first = rdata;
    repeat (20) idle_cycle(1'b0);
    drive_op(`CSR_MCYCLE_ADDR, OP_READ, 32'h0, PRIV_M);
    expect_value("mcycle while inhibited", rdata, first);
    drive_op(`CSR_MCOUNTINHIBIT_ADDR, OP_WRITE, 32'h4, PRIV_M);
    drive_op(`CSR_MINSTRET_ADDR, OP_READ, 32'h0, PRIV_M);
    first = rdata;
    repeat (10) idle_cycle(1'b1);
    drive_op(`CSR_MINSTRET_ADDR, OP_READ, 32'h0, PRIV_M);
    expect_value("minstret while inhibited", rdata, first);
    drive_op(`CSR_MCOUNTINHIBIT_ADDR, OP_WRITE, 32'h0, PRIV_M);
    repeat (5) begin
      drive_op(`CSR_MINSTRET_ADDR, OP_READ, 32'h0, PRIV_M);
      first  = rdata;
      pulses = 0;
      n      = 1 + $unsigned($random(seed)) % 40;
      repeat (n) begin
        rnd    = $random(seed);
        pulses = pulses + rnd[0];
        idle_cycle(rnd[0]);
      end
      drive_op(`CSR_MINSTRET_ADDR, OP_READ, 32'h0, PRIV_M);
      expect_value("minstret step", rdata - first, pulses);
    end
    operand = $random(seed) & 32'h7fff_ffff;
    drive_op(`CSR_MCYCLE_ADDR, OP_WRITE, operand, PRIV_M);
    check_read(`CSR_MCYCLE_ADDR, operand);
    check_read(`CSR_MCYCLE_ADDR, operand + 1);  // Counting again
    operand = $random(seed);
    drive_op(`CSR_MCYCLEH_ADDR, OP_WRITE, operand, PRIV_M);
    check_read(`CSR_MCYCLEH_ADDR, operand);
    operand = $random(seed) & 32'h7fff_ffff;
    drive_op(`CSR_MINSTRET_ADDR, OP_WRITE, operand, PRIV_M);
    check_read(`CSR_MINSTRET_ADDR, operand);
    idle_cycle(1'b1);
    inst_value = operand + 1;  // No more pulses until the end of the U-mode test
    check_read(`CSR_MINSTRET_ADDR, inst_value);
    operand = $random(seed);
    drive_op(`CSR_MINSTRETH_ADDR, OP_WRITE, operand, PRIV_M);
    check_read(`CSR_MINSTRETH_ADDR, operand);
    close_test("counters");

    // 5. U-mode shadows gated by mcounteren
    for (int k = 0; k < 4; k++) begin
      en_bits = k[1:0];
      operand = ($random(seed) & ~32'h5) | {29'h0, en_bits[1], 1'b0, en_bits[0]};
      drive_op(`CSR_MCOUNTEREN_ADDR, OP_WRITE, operand, PRIV_M);
      model_reg[8] = legalize(8, operand);
      check_read(`CSR_MCOUNTEREN_ADDR, model_reg[8]);
      drive_op(`CSR_CYCLE_ADDR, OP_READ, 32'h0, PRIV_U);
      expect_value("U-mode cycle fault", invalid_csr, !en_bits[0]);
      if (!en_bits[0])
        expect_value("blocked cycle data", rdata, 0);
      drive_op(`CSR_CYCLEH_ADDR, OP_READ, 32'h0, PRIV_U);
      expect_value("U-mode cycleh fault", invalid_csr, !en_bits[0]);
      drive_op(`CSR_INSTRET_ADDR, OP_READ, 32'h0, PRIV_U);
      expect_value("U-mode instret fault", invalid_csr, !en_bits[1]);
      expect_value("U-mode instret data", rdata, en_bits[1] ? inst_value : 32'h0);
      drive_op(`CSR_INSTRETH_ADDR, OP_READ, 32'h0, PRIV_U);
      expect_value("U-mode instreth fault", invalid_csr, !en_bits[1]);
    end
    close_test("user counter access");

    // 6. Injection against a same-cycle software write
    for (int i = 0; i < INJECTIONS; i++) begin
      rnd            = $random(seed);
      inj            = '0;
      inj.mstatus_en = rnd[0];
      inj.mepc_en    = rnd[1];
      inj.mcause_en  = rnd[2];
      inj.mtval_en   = rnd[3];
      inj.mip_en     = rnd[4];
      inj.mstatus    = mstatus_t'($random(seed));
      inj.mepc       = $random(seed);
      inj.mcause     = $random(seed);
      inj.mtval      = $random(seed);
      inj.mip        = mip_t'($random(seed));
      pick           = rnd[7:5] % 5;
      idx            = (pick == 0) ? 0 : (pick == 1) ? 3 : pick + 3;
      operand        = $random(seed);
      @(posedge CLK);
      req       <= {reg_addr(idx), OP_WRITE, operand};
      curr_priv <= PRIV_M;
      inject    <= inj;
      model_reg[idx] = legalize(idx, operand);
      if (inj.mstatus_en)
        model_reg[0] = legalize(0, inj.mstatus);
      if (inj.mip_en)
        model_reg[3] = legalize(3, inj.mip);
      if (inj.mepc_en)
        model_reg[5] = inj.mepc;
      if (inj.mcause_en)
        model_reg[6] = inj.mcause;
      if (inj.mtval_en)
        model_reg[7] = inj.mtval;
      check_read(reg_addr(idx), model_reg[idx]);
      expect_value("trap_state mstatus", trap_state.mstatus, model_reg[0]);
      expect_value("trap_state mtvec", trap_state.mtvec, model_reg[1]);
      expect_value("trap_state mie", trap_state.mie, model_reg[2]);
      expect_value("trap_state mip", trap_state.mip, model_reg[3]);
      expect_value("trap_state mepc", trap_state.mepc, model_reg[5]);
      expect_value("trap_state mcause", trap_state.mcause, model_reg[6]);
    end
    check_read(`CSR_MTVAL_ADDR, model_reg[7]);
    close_test("injection");

    errors = errors + u_csr_file_top.u_assertions.fail_count;
    $display("Tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, checks, errors, u_csr_file_top.u_assertions.fail_count);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_access_check.sv
verilog/csr_machine_regs.sv
verilog/csr_counter64.sv
verilog/csr_read_mux.sv
verilog/csr_file_top.sv
bench/csr_file_assertions.sv
bench/csr_file_tb.sv
